// ==== dv/decode_stim.txt ====
# fv pc instr kill mem_rd mem_we wb_we wb_rd wb_data | chk stall valid rd alu imm rs1d rs2d flags
# flags = {illegal, reg_write, mem_read, mem_write, jump}, all hex
0 0 00000000 0 0 0 1 01 00001000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 1 02 00002000 1 0 0 0 0 0 0 0 00
1 100 FFD08293 0 0 0 1 03 33333333 0 0 0 0 0 0 0 0 00
1 104 00310333 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
1 108 123453B7 0 0 0 0 00 00000000 1 0 1 05 3 FFFFFFFD 00001000 00000000 08
1 10C 80000497 0 0 0 0 00 00000000 1 0 1 06 2 00000000 00002000 33333333 08
1 110 0080A503 0 0 0 0 00 00000000 1 0 1 07 4 12345000 00000000 33333333 08
1 114 FE312E23 0 0 0 0 00 00000000 1 0 1 09 5 80000000 00000000 00000000 08
1 118 FE208CE3 0 0 0 0 00 00000000 1 0 1 0A 0 00000008 00001000 00000000 0C
1 11C 001000EF 0 0 0 0 00 00000000 1 0 1 00 0 FFFFFFFC 00002000 33333333 02
1 120 FF0105E7 0 0 0 0 00 00000000 1 0 1 00 1 FFFFFFF8 00001000 00002000 00
1 124 0000007F 0 0 0 0 00 00000000 1 0 1 01 6 00000800 00000000 00001000 09
0 0 00000000 0 0 0 0 00 00000000 1 0 1 0B 7 FFFFFFF0 00002000 00000000 09
0 0 00000000 0 0 0 0 00 00000000 1 0 1 00 3 00000000 00000000 00000000 10
1 200 00310333 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 1 02 CAFEF00D 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 1 06 2 00000000 CAFEF00D 33333333 08
1 204 00000333 0 0 0 1 00 FFFFFFFF 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 1 00 FFFFFFFF 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 1 06 2 00000000 00000000 00000000 08
1 300 FFD08293 0 0 0 0 00 00000000 0 0 0 0 0 0 0 0 00
1 304 00328633 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
1 308 000606B7 0 0 0 0 00 00000000 1 1 1 05 3 FFFFFFFD 00001000 00000000 08
1 308 000606B7 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
1 30C 00D0A023 0 0 0 0 00 00000000 1 0 1 0C 2 00000000 00000000 33333333 08
0 0 00000000 0 0 0 0 00 00000000 1 1 1 0D 4 00060000 00000000 00000000 08
0 0 00000000 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 1 00 0 00000000 00001000 00000000 02
1 400 FFD08293 0 0 0 0 00 00000000 0 0 0 0 0 0 0 0 00
0 0 00000000 0 01 1 0 00 00000000 1 1 0 0 0 0 0 0 00
0 0 00000000 0 01 1 0 00 00000000 1 1 0 0 0 0 0 0 00
0 0 00000000 0 01 0 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 1 05 3 FFFFFFFD 00001000 00000000 08
1 404 00000333 0 0 0 0 00 00000000 0 0 0 0 0 0 0 0 00
0 0 00000000 0 00 1 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 1 06 2 00000000 00000000 00000000 08
1 500 FFD08293 0 0 0 0 00 00000000 0 0 0 0 0 0 0 0 00
1 504 00310333 1 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00
0 0 00000000 0 0 0 0 00 00000000 1 0 0 0 0 0 0 0 00

// ==== riscv_decode.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/id_latch.sv
logic/reg_file.sv
logic/instr_decoder.sv
logic/ex_latch.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_decode

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/id_latch.sv
      - logic/reg_file.sv
      - logic/instr_decoder.sv
      - logic/ex_latch.sv
      - logic/decode_stage.sv

  - target: test
    files:
      - dv/decode_stage_tb.sv

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32I decode stage
// Replays the stimulus file cycle by cycle and checks the ID/EX bundle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module decode_stage_tb;

	import pipe_pkg::*;

	// One stimulus line, inputs first and then the expected outputs
	typedef struct packed {
		logic        fv;
		logic [31:0] pc;
		logic [31:0] instr;
		logic        kill;
		logic [4:0]  mem_rd;
		logic        mem_we;
		logic        wb_we;
		logic [4:0]  wb_rd;
		logic [31:0] wb_data;
		logic        chk;
		logic        stall;
		logic        valid;
		logic [4:0]  rd;
		logic [2:0]  alu_op;
		logic [31:0] imm;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		// illegal, reg_write, mem_read, mem_write, jump
		logic [4:0]  flags;
	} stim_line_t;

	logic       clk;
	logic       rst_n;
	id_state_t  fetch;
	logic       kill;
	stage_dst_t mem_dst;
	wb_port_t   wb;
	ex_state_t  ex_state;
	logic       stall;

	stim_line_t lines[$];
	// Accepted fetches still on their way to execute, oldest first
	id_state_t  issued[$];
	int         errors = 0;
	int         tests = 0;
	int         failed_tests = 0;
	int         cycle_count = 0;
	int         cycle_limit = 1000;

	decode_stage u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.fetch    (fetch),
		.kill     (kill),
		.mem_dst  (mem_dst),
		.wb       (wb),
		.ex_state (ex_state),
		.stall    (stall)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       text;
		logic [31:0] col [0:17];
		stim_line_t  s;
		fd = $fopen("dv/decode_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/decode_stim.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				// Comment and blank lines
				if (n == 0 || text.getc(0) == "#" || text.getc(0) == "\n") begin
					continue;
				end
				n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14],
					col[15], col[16], col[17]);
				if (n != 18) begin
					$display("stimulus line %0d has %0d columns instead of 18", lines.size(), n);
					errors++;
				end else begin
					s = '{col[0][0], col[1], col[2], col[3][0], col[4][4:0], col[5][0],
						col[6][0], col[7][4:0], col[8], col[9][0], col[10][0], col[11][0],
						col[12][4:0], col[13][2:0], col[14], col[15], col[16], col[17][4:0]};
					lines.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_line(input stim_line_t s);
		fetch   <= '{valid: s.fv, pc: s.pc, instruction: s.instr};
		kill    <= s.kill;
		mem_dst <= '{rd: s.mem_rd, reg_write: s.mem_we};
		wb      <= '{we: s.wb_we, rd: s.wb_rd, data: s.wb_data};
	endtask

	// Kill flushes everything in flight, otherwise an unstalled fetch is taken
	task automatic track_issue(input stim_line_t s);
		id_state_t entry;
		entry = '{valid: 1'b1, pc: s.pc, instruction: s.instr};
		if (s.kill) begin
			issued.delete();
		end else if (s.fv && !s.stall) begin
			issued.push_back(entry);
		end
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int line_no, inout int errs);
		if (got !== exp) begin
			$display("mismatch %s at line %0d: got %h expected %h", name, line_no, got, exp);
			errs++;
		end
	endtask

	task automatic check_line(input stim_line_t s, input int line_no);
		int          errs;
		logic [4:0]  got_flags;
		id_state_t   exp_id;
		errs = 0;
		exp_id = '0;
		got_flags = {ex_state.illegal, ex_state.reg_write, ex_state.mem_read,
			ex_state.mem_write, ex_state.jump};
		compare_field("stall", stall, s.stall, line_no, errs);
		compare_field("ex_state.valid", ex_state.valid, s.valid, line_no, errs);
		compare_field("ex_state.flags", got_flags, s.flags, line_no, errs);
		// A bubble carries no meaningful payload
		if (s.valid) begin
			if (issued.size() == 0) begin
				$display("line %0d expects an instruction but none was issued", line_no);
				errs++;
			end else begin
				exp_id = issued.pop_front();
			end
			compare_field("ex_state.pc", ex_state.pc, exp_id.pc, line_no, errs);
			compare_field("ex_state.rs1", ex_state.rs1, exp_id.instruction[19:15],
				line_no, errs);
			compare_field("ex_state.rs2", ex_state.rs2, exp_id.instruction[24:20],
				line_no, errs);
			compare_field("ex_state.func3", ex_state.func3, exp_id.instruction[14:12],
				line_no, errs);
			compare_field("ex_state.func7_bit", ex_state.func7_bit, exp_id.instruction[30],
				line_no, errs);
			// Only loads take their result from memory
			compare_field("ex_state.mem_to_reg", ex_state.mem_to_reg, s.flags[2],
				line_no, errs);
			compare_field("ex_state.rd", ex_state.rd, s.rd, line_no, errs);
			compare_field("ex_state.alu_op", ex_state.alu_op, s.alu_op, line_no, errs);
			compare_field("ex_state.immediate", ex_state.immediate, s.imm, line_no, errs);
			compare_field("ex_state.rs1_data", ex_state.rs1_data, s.rs1_data, line_no, errs);
			compare_field("ex_state.rs2_data", ex_state.rs2_data, s.rs2_data, line_no, errs);
		end
		tests++;
		if (errs != 0) begin
			failed_tests++;
			errors += errs;
			$display("test %0d at line %0d: failed", tests, line_no);
		end else begin
			$display("test %0d at line %0d: ok", tests, line_no);
		end
	endtask

	initial begin
		rst_n   <= 1'b0;
		fetch   <= '0;
		kill    <= 1'b0;
		mem_dst <= '0;
		wb      <= '0;
		load_stimulus();
		cycle_limit = 4 * lines.size() + 20;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		foreach (lines[k]) begin
			@(posedge clk);
			apply_line(lines[k]);
			// Outputs are settled by the falling edge
			@(negedge clk);
			if (lines[k].chk) begin
				check_line(lines[k], k);
			end
			track_issue(lines[k]);
		end
		@(posedge clk);
		fetch   <= '0;
		kill    <= 1'b0;
		mem_dst <= '0;
		wb      <= '0;
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0 && tests > 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage of the five-stage RV32I pipeline
// IF/ID register, register file, decoder and ID/EX register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module decode_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  pipe_pkg::id_state_t  fetch,
	input  logic                 kill,
	input  pipe_pkg::stage_dst_t mem_dst,
	input  pipe_pkg::wb_port_t   wb,
	output pipe_pkg::ex_state_t  ex_state,
	output logic                 stall
);

	import isa_pkg::*;
	import pipe_pkg::*;

	id_state_t       id_q;
	ex_state_t       dec;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	id_latch u_id_latch (
		.clk   (clk),
		.rst_n (rst_n),
		.fetch (fetch),
		.stall (stall),
		.kill  (kill),
		.id_q  (id_q)
	);

	// Source indices come straight from the held word
	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (id_q.instruction[19:15]),
		.rs2      (id_q.instruction[24:20]),
		.wb       (wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	instr_decoder u_instr_decoder (
		.id_q     (id_q),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.ex_dst   (ex_state),
		.mem_dst  (mem_dst),
		.dec      (dec),
		.stall    (stall)
	);

	ex_latch u_ex_latch (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec      (dec),
		.stall    (stall),
		.kill     (kill),
		.ex_state (ex_state)
	);

endmodule

`default_nettype wire

// ==== logic/ex_latch.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register
// Loads the decoded bundle, or a bubble on stall, kill or an empty slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_latch (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::ex_state_t dec,
	input  logic                stall,
	input  logic                kill,
	output pipe_pkg::ex_state_t ex_state
);

	import pipe_pkg::*;

	logic      bubble;
	logic      valid_q;
	logic      reg_write_q;
	logic      mem_read_q;
	logic      mem_write_q;
	logic      mem_to_reg_q;
	logic      jump_q;
	logic      illegal_q;
	ex_state_t payload_q;

	assign bubble = stall || kill || !dec.valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q      <= 1'b0;
			reg_write_q  <= 1'b0;
			mem_read_q   <= 1'b0;
			mem_write_q  <= 1'b0;
			mem_to_reg_q <= 1'b0;
			jump_q       <= 1'b0;
			illegal_q    <= 1'b0;
		end else begin
			// A bubble clears every control bit
			valid_q      <= !bubble;
			reg_write_q  <= dec.reg_write && !bubble;
			mem_read_q   <= dec.mem_read && !bubble;
			mem_write_q  <= dec.mem_write && !bubble;
			mem_to_reg_q <= dec.mem_to_reg && !bubble;
			jump_q       <= dec.jump && !bubble;
			illegal_q    <= dec.illegal && !bubble;
		end
	end

	// Operands, indices and immediate only move with a real instruction
	always_ff @(posedge clk) begin
		if (!bubble) begin
			payload_q <= dec;
		end
	end

	always_comb begin
		ex_state            = payload_q;
		ex_state.valid      = valid_q;
		ex_state.reg_write  = reg_write_q;
		ex_state.mem_read   = mem_read_q;
		ex_state.mem_write  = mem_write_q;
		ex_state.mem_to_reg = mem_to_reg_q;
		ex_state.jump       = jump_q;
		ex_state.illegal    = illegal_q;
	end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction decoder
// Builds controls and immediates, and stalls on source hazards
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module instr_decoder (
	input  pipe_pkg::id_state_t      id_q,
	input  logic [isa_pkg::xlen-1:0] rs1_data,
	input  logic [isa_pkg::xlen-1:0] rs2_data,
	input  pipe_pkg::ex_state_t      ex_dst,
	input  pipe_pkg::stage_dst_t     mem_dst,
	output pipe_pkg::ex_state_t      dec,
	output logic                     stall
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0]       instr;
	opcode_e               opcode;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       imm_j;
	logic                  uses_rs1;
	logic                  uses_rs2;
	logic                  rs1_hazard;
	logic                  rs2_hazard;

	// A later stage will write the register this source reads
	function automatic logic dst_hit(
		input logic [reg_addr_w-1:0] src,
		input logic [reg_addr_w-1:0] dst,
		input logic                  dst_we
	);
		return dst_we && (dst != '0) && (src == dst);
	endfunction

	assign instr  = id_q.instruction;
	assign opcode = opcode_e'(instr[opcode_w-1:0]);
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	// Immediates per format, all sign extended from bit 31
	assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
	assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

	always_comb begin
		dec           = '0;
		dec.valid     = id_q.valid;
		dec.pc        = id_q.pc;
		dec.rs1       = rs1;
		dec.rs2       = rs2;
		dec.rd        = rd;
		dec.rs1_data  = rs1_data;
		dec.rs2_data  = rs2_data;
		dec.func3     = instr[14:12];
		dec.func7_bit = instr[30];
		dec.alu_op    = alu_imm;
		uses_rs1      = 1'b0;
		uses_rs2      = 1'b0;

		case (opcode)
			op_reg: begin
				dec.alu_op    = alu_reg;
				dec.reg_write = 1'b1;
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			op_imm: begin
				dec.alu_op    = alu_imm;
				dec.immediate = imm_i;
				dec.reg_write = 1'b1;
				uses_rs1      = 1'b1;
			end
			op_lui: begin
				dec.alu_op    = alu_lui;
				dec.immediate = imm_u;
				dec.reg_write = 1'b1;
			end
			op_auipc: begin
				dec.alu_op    = alu_auipc;
				dec.immediate = imm_u;
				dec.reg_write = 1'b1;
			end
			op_load: begin
				dec.alu_op     = alu_mem_addr;
				dec.immediate  = imm_i;
				dec.reg_write  = 1'b1;
				dec.mem_read   = 1'b1;
				dec.mem_to_reg = 1'b1;
				uses_rs1       = 1'b1;
			end
			op_store: begin
				dec.alu_op    = alu_mem_addr;
				dec.immediate = imm_s;
				dec.mem_write = 1'b1;
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			op_branch: begin
				dec.alu_op    = alu_branch;
				dec.immediate = imm_b;
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			op_jal: begin
				dec.alu_op    = alu_jal;
				dec.immediate = imm_j;
				dec.reg_write = 1'b1;
				dec.jump      = 1'b1;
			end
			op_jalr: begin
				dec.alu_op    = alu_jalr;
				dec.immediate = imm_i;
				dec.reg_write = 1'b1;
				dec.jump      = 1'b1;
				uses_rs1      = 1'b1;
			end
			default: begin
				// No write controls, execute sees a dead slot
				dec.illegal = 1'b1;
			end
		endcase

		// No destination unless the register is written
		if (!dec.reg_write) begin
			dec.rd = '0;
		end
	end

	// Execute and memory stages are both checked, no forwarding
	assign rs1_hazard = dst_hit(rs1, ex_dst.rd, ex_dst.reg_write) ||
		dst_hit(rs1, mem_dst.rd, mem_dst.reg_write);
	assign rs2_hazard = dst_hit(rs2, ex_dst.rd, ex_dst.reg_write) ||
		dst_hit(rs2, mem_dst.rd, mem_dst.reg_write);

	assign stall = id_q.valid && ((uses_rs1 && rs1_hazard) || (uses_rs2 && rs2_hazard));

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file, two read ports and one write port
// Same-cycle writes pass through to the read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [isa_pkg::reg_addr_w-1:0] rs1,
	input  logic [isa_pkg::reg_addr_w-1:0] rs2,
	input  pipe_pkg::wb_port_t            wb,
	output logic [isa_pkg::xlen-1:0]       rs1_data,
	output logic [isa_pkg::xlen-1:0]       rs2_data
);

	import isa_pkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:num_regs-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
		logic [xlen-1:0] value;
		if (addr == '0) begin
			value = '0;
		end else if (wb.we && wb.rd == addr) begin
			// Write-through from writeback
			value = wb.data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

`default_nettype wire

// ==== logic/id_latch.sv ====
`timescale 1ns/100ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IF/ID pipeline register
// Holds the waiting instruction on stall and drops it on kill
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module id_latch (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::id_state_t fetch,
	input  logic                stall,
	input  logic                kill,
	output pipe_pkg::id_state_t id_q
);

	import isa_pkg::*;

	logic            valid_q;
	logic [xlen-1:0] pc_q;
	logic [xlen-1:0] instr_q;

	// Slot empties when fetch has nothing and decode is free
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (kill) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= fetch.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch.valid && !stall) begin
			pc_q    <= fetch.pc;
			instr_q <= fetch.instruction;
		end
	end

	assign id_q = '{valid: valid_q, pc: pc_q, instruction: instr_q};

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bundles carried between the fetch, decode, execute and later stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pipe_pkg;

	import isa_pkg::*;

	// Fetched word as held in the IF/ID register
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instruction;
	} id_state_t;

	// Decoded bundle handed to execute
	typedef struct packed {
		logic                  valid;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       rs1_data;
		logic [xlen-1:0]       rs2_data;
		logic [xlen-1:0]       immediate;
		logic [func3_w-1:0]    func3;
		// Bit 30, selects sub and sra
		logic                  func7_bit;
		alu_op_e               alu_op;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic                  mem_to_reg;
		logic                  jump;
		logic                  illegal;
	} ex_state_t;

	// Destination of a later stage, for hazard checks
	typedef struct packed {
		logic [reg_addr_w-1:0] rd;
		logic                  reg_write;
	} stage_dst_t;

	// Register file write from writeback
	typedef struct packed {
		logic                  we;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       data;
	} wb_port_t;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I encoding definitions used by the decode stage
// Major opcodes, execute operation codes and instruction field widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package isa_pkg;

	// Data path and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	// Instruction field widths
	localparam int opcode_w = 7;
	localparam int func3_w  = 3;
	localparam int alu_op_w = 3;

	// Major opcodes, taken from bits [6:0] of the word
	typedef enum logic [opcode_w-1:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111
	} opcode_e;

	// What the execute stage does with the operands
	typedef enum logic [alu_op_w-1:0] {
		// Address add for loads and stores
		alu_mem_addr = 3'b000,
		alu_branch   = 3'b001,
		alu_reg      = 3'b010,
		alu_imm      = 3'b011,
		alu_lui      = 3'b100,
		alu_auipc    = 3'b101,
		// Link address and target for jumps
		alu_jal      = 3'b110,
		alu_jalr     = 3'b111
	} alu_op_e;

endpackage

`default_nettype wire
